/* hdl/lsu_macros.svh */
// Width and depth settings for the load/store unit
// Included by the package and by every RTL file that sizes a signal

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

// Data and address width
`define LSU_XLEN 32

// One enable per byte lane
`define LSU_BE_W 4

//////////////////////////////////////////////////
// Outstanding transfer tracking
//////////////////////////////////////////////////

`define LSU_MAX_OUTSTND 2
`define LSU_CNT_W 2

`endif

/* hdl/lsu_pkg.sv */
// Types shared by the load/store unit: access size, EX op and bus payloads
// Modules import it in their body and use scoped names on their ports

`include "lsu_macros.svh"

package lsu_pkg;

  // Access size, same code as the funct3 low bits
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10
  } lsu_size_e;

  // Load/store instruction as presented in EX
  typedef struct packed {
    logic [`LSU_XLEN-1:0] operand_a;
    logic [`LSU_XLEN-1:0] operand_b;
    logic [`LSU_XLEN-1:0] wdata;
    logic                 we;
    lsu_size_e            size;
    logic                 sext;
  } lsu_op_t;

  // Address phase of the data bus
  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
    logic                 we;
    logic [`LSU_BE_W-1:0] be;
    logic [`LSU_XLEN-1:0] wdata;
  } bus_req_t;

  // Response phase of the data bus
  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;
    logic                 err;
  } bus_resp_t;

  // Control carried from EX to WB for realignment
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;
    // Low only for the first half of a split
    logic       last;
  } wb_ctrl_t;

endpackage

/* hdl/lsu_addr_stage.sv */
// EX side of the load/store unit: address, split tracking, byte enables, store data
// Drives the bus payload and the control word that follows the access into WB

`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_addr_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::lsu_op_t  op_i,
  input  logic              valid_0_i,
  input  logic              ctrl_update_i,
  output lsu_pkg::bus_req_t req_payload_o,
  output lsu_pkg::wb_ctrl_t wb_next_o,
  output logic              split_0_o,
  output logic              split_q_o,
  output logic              first_op_0_o,
  output logic              last_op_0_o
);

  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] addr;
  logic [1:0]           offset;
  logic [`LSU_BE_W-1:0] be;
  logic [`LSU_XLEN-1:0] wdata_rot;
  // Second address phase of a split access in progress
  logic                 split_q;

  assign addr   = op_i.operand_a + op_i.operand_b;
  assign offset = addr[1:0];

  // Split needed for a word off alignment or a halfword crossing the word
  always_comb begin
    split_0_o = 1'b0;
    if (valid_0_i && !split_q) begin
      if (op_i.size == LSU_SIZE_WORD && offset != 2'b00) begin
        split_0_o = 1'b1;
      end
      if (op_i.size == LSU_SIZE_HALF && offset == 2'b11) begin
        split_0_o = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////

  always_comb begin
    case (op_i.size)
      LSU_SIZE_BYTE: be = 4'b0001 << offset;
      LSU_SIZE_HALF: begin
        // Second half only carries the top byte into lane 0
        if (split_q) be = 4'b0001;
        else         be = (offset == 2'b11) ? 4'b1000 : (4'b0011 << offset);
      end
      default: begin
        // Word, first half fills the upper lanes
        if (split_q) be = 4'b1111 >> (3'd4 - {1'b0, offset});
        else         be = 4'b1111 << offset;
      end
    endcase
  end

  // Rotate store data left so byte 0 lands in lane offset
  always_comb begin
    case (offset)
      2'b00:   wdata_rot = op_i.wdata;
      2'b01:   wdata_rot = {op_i.wdata[23:0], op_i.wdata[31:24]};
      2'b10:   wdata_rot = {op_i.wdata[15:0], op_i.wdata[31:16]};
      default: wdata_rot = {op_i.wdata[7:0], op_i.wdata[31:8]};
    endcase
  end

  // Second half goes to the next aligned word
  always_comb begin
    req_payload_o.addr  = split_q ? ({addr[`LSU_XLEN-1:2], 2'b00} + `LSU_XLEN'd4) : addr;
    req_payload_o.we    = op_i.we;
    req_payload_o.be    = be;
    req_payload_o.wdata = wdata_rot;
  end

  // Control word for WB, taken on ctrl_update
  always_comb begin
    wb_next_o.size   = op_i.size;
    wb_next_o.sext   = op_i.sext;
    wb_next_o.we     = op_i.we;
    wb_next_o.offset = offset;
    wb_next_o.last   = !split_0_o;
  end

  // Cleared on an empty EX so a killed split cannot leak into the next op
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;
    end else if (ctrl_update_i) begin
      split_q <= split_0_o;
    end
  end

  assign split_q_o    = split_q;
  assign first_op_0_o = !split_q;
  assign last_op_0_o  = !split_0_o;

endmodule

/* hdl/lsu_txn_ctrl.sv */
// Transfer control for the load/store unit: outstanding count, request, handshakes
// Also derives busy, interruptible and the protocol error flag

`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_txn_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_0_i,
  input  logic ready_0_i,
  input  logic valid_1_i,
  input  logic ready_1_i,
  input  logic split_0_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,
  output logic ready_0_o,
  output logic valid_0_o,
  output logic valid_1_o,
  output logic ready_1_o,
  output logic ctrl_update_o,
  output logic busy_o,
  output logic interruptible_o,
  output logic protocol_err_o
);

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_next;
  logic                  cnt_zero;
  logic                  trans_valid;
  logic                  count_up;
  logic                  count_down;
  // EX address phase finished
  logic                  done_0;
  // Request seen for more than one cycle without completing
  logic                  trans_valid_q;

  assign cnt_zero = (cnt_q == '0);

  // Request only while below the outstanding limit
  assign trans_valid = valid_0_i && (cnt_q < `LSU_CNT_W'(`LSU_MAX_OUTSTND));
  assign data_req_o  = trans_valid;

  //////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////

  assign count_up   = trans_valid && data_gnt_i;
  // Stray responses do not underflow
  assign count_down = data_rvalid_i && !cnt_zero;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_next = cnt_q + 1'b1;
      2'b01:   cnt_next = cnt_q - 1'b1;
      default: cnt_next = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) cnt_q <= '0;
    else        cnt_q <= cnt_next;
  end

  //////////////////////////////////////////////////
  // EX and WB handshakes
  //////////////////////////////////////////////////

  // An empty EX is done; a valid one only once its transfer is granted
  assign done_0        = (!valid_0_i || count_up) && ready_0_i;
  assign valid_0_o     = count_up && valid_0_i;
  assign ctrl_update_o = done_0 && valid_0_i;
  // Hold EX while the first half of a split is on the bus
  assign ready_0_o     = done_0 && !split_0_i;

  // WB free when nothing is in flight, else when the response lands
  assign ready_1_o = (cnt_zero ? 1'b1 : data_rvalid_i) && ready_1_i;
  assign valid_1_o = data_rvalid_i && valid_1_i;

  // A request must not be retracted once it has waited a cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trans_valid_q <= 1'b0;
    end else if (ctrl_update_o) begin
      trans_valid_q <= 1'b0;
    end else if (trans_valid) begin
      trans_valid_q <= 1'b1;
    end
  end

  assign interruptible_o = !trans_valid_q && cnt_zero;
  assign busy_o          = !cnt_zero || trans_valid;
  // Response with nothing granted
  assign protocol_err_o  = data_rvalid_i && cnt_zero;

endmodule

/* hdl/lsu_rdata_align.sv */
// WB side of the load/store unit: control queue, split load joining and extension
// Produces the register file value in the cycle of the final response

`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_rdata_align (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ctrl_update_i,
  input  lsu_pkg::wb_ctrl_t  wb_next_i,
  input  logic               split_0_i,
  input  logic               split_q_i,
  input  logic               data_rvalid_i,
  input  lsu_pkg::bus_resp_t data_resp_i,
  output logic [31:0]        lsu_rdata_1_o,
  output logic               lsu_err_1_o
);

  import lsu_pkg::*;

  localparam int PTR_W = $clog2(`LSU_MAX_OUTSTND);

  // One control word per outstanding transfer
  wb_ctrl_t               wb_q [`LSU_MAX_OUTSTND];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  wb_ctrl_t               wb_head;
  logic [`LSU_XLEN-1:0]   rdata_q;
  logic                   rdata_is_split;
  logic [2*`LSU_XLEN-1:0] rdata_full;
  logic [2*`LSU_XLEN-1:0] rdata_shift;
  logic [`LSU_XLEN-1:0]   rdata_aligned;

  //////////////////////////////////////////////////
  // WB control queue
  //////////////////////////////////////////////////

  // Push on each EX address phase, pop on each response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q     <= '{default: '0};
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (ctrl_update_i) begin
        wb_q[wr_ptr_q] <= wb_next_i;
        wr_ptr_q       <= wr_ptr_q + 1'b1;
      end
      if (data_rvalid_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  assign wb_head = wb_q[rd_ptr_q];

  // Low half of a split load, kept for the second response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (data_rvalid_i && !wb_head.we && !wb_head.last) begin
      rdata_q <= data_resp_i.rdata;
    end
  end

  //////////////////////////////////////////////////
  // Realignment and extension
  //////////////////////////////////////////////////

  assign rdata_is_split = (wb_head.size == LSU_SIZE_WORD && wb_head.offset != 2'b00) ||
                          (wb_head.size == LSU_SIZE_HALF && wb_head.offset == 2'b11);

  // Unsplit data is doubled so the shift wraps the upper bytes down
  assign rdata_full    = rdata_is_split ? {data_resp_i.rdata, rdata_q} :
                                          {data_resp_i.rdata, data_resp_i.rdata};
  assign rdata_shift   = rdata_full >> {wb_head.offset, 3'b000};
  assign rdata_aligned = rdata_shift[`LSU_XLEN-1:0];

  always_comb begin
    case (wb_head.size)
      LSU_SIZE_BYTE: begin
        lsu_rdata_1_o = {{24{wb_head.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      end
      LSU_SIZE_HALF: begin
        lsu_rdata_1_o = {{16{wb_head.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      end
      default: lsu_rdata_1_o = rdata_aligned;
    endcase
  end

  // Bus error only counts on a response cycle
  assign lsu_err_1_o = data_resp_i.err && data_rvalid_i;

endmodule

/* hdl/load_store_unit.sv */
// Top of the load/store unit for a small in-order RISC-V pipeline
// Connects the EX address stage, transfer control and WB realignment to the data bus

`timescale 1ns/1ps

module load_store_unit (
  input  logic               clk,
  input  logic               rst_n,
  // EX side
  input  lsu_pkg::lsu_op_t   op_i,
  input  logic               valid_0_i,
  output logic               ready_0_o,
  output logic               valid_0_o,
  input  logic               ready_0_i,
  // WB side
  input  logic               valid_1_i,
  output logic               ready_1_o,
  output logic               valid_1_o,
  input  logic               ready_1_i,
  // Data bus
  output logic               data_req_o,
  output lsu_pkg::bus_req_t  data_req_payload_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  lsu_pkg::bus_resp_t data_resp_i,
  // Results and status
  output logic [31:0]        lsu_rdata_1_o,
  output logic               lsu_err_1_o,
  output logic               split_0_o,
  output logic               first_op_0_o,
  output logic               last_op_0_o,
  output logic               busy_o,
  output logic               interruptible_o,
  output logic               protocol_err_o
);

  import lsu_pkg::*;

  wb_ctrl_t wb_next;
  logic     split_q;
  // EX address phase done, WB takes over
  logic     ctrl_update;

  lsu_addr_stage i_addr_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_i         (op_i),
    .valid_0_i    (valid_0_i),
    .ctrl_update_i(ctrl_update),
    .req_payload_o(data_req_payload_o),
    .wb_next_o    (wb_next),
    .split_0_o    (split_0_o),
    .split_q_o    (split_q),
    .first_op_0_o (first_op_0_o),
    .last_op_0_o  (last_op_0_o)
  );

  lsu_txn_ctrl i_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_0_i      (valid_0_i),
    .ready_0_i      (ready_0_i),
    .valid_1_i      (valid_1_i),
    .ready_1_i      (ready_1_i),
    .split_0_i      (split_0_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .ready_0_o      (ready_0_o),
    .valid_0_o      (valid_0_o),
    .valid_1_o      (valid_1_o),
    .ready_1_o      (ready_1_o),
    .ctrl_update_o  (ctrl_update),
    .busy_o         (busy_o),
    .interruptible_o(interruptible_o),
    .protocol_err_o (protocol_err_o)
  );

  lsu_rdata_align i_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_update_i(ctrl_update),
    .wb_next_i    (wb_next),
    .split_0_i    (split_0_o),
    .split_q_i    (split_q),
    .data_rvalid_i(data_rvalid_i),
    .data_resp_i  (data_resp_i),
    .lsu_rdata_1_o(lsu_rdata_1_o),
    .lsu_err_1_o  (lsu_err_1_o)
  );

endmodule

/* testbench/tb_clk_gen.sv */
// Clock and reset source for the load/store unit testbench
// 10 ns clock, reset held low for the first 4 cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* testbench/lsu_props.sv */
// Bus and handshake assertions for the load/store unit
// Bound into load_store_unit at the bottom of this file

`timescale 1ns/1ps

module lsu_props (
  input logic              clk,
  input logic              rst_n,
  input logic              data_req_i,
  input logic              data_gnt_i,
  input lsu_pkg::bus_req_t req_payload_i,
  input logic              valid_0_i,
  input logic              data_rvalid_i,
  input logic              protocol_err_i
);

  // Transfers granted and still waiting for their response
  logic [1:0] granted_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      granted_q <= '0;
    end else begin
      case ({data_req_i && data_gnt_i, data_rvalid_i && granted_q != 2'd0})
        2'b10:   granted_q <= granted_q + 2'd1;
        2'b01:   granted_q <= granted_q - 2'd1;
        default: granted_q <= granted_q;
      endcase
    end
  end

  // Waiting request keeps its payload while EX holds the op
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i && !data_gnt_i && valid_0_i |=>
      !valid_0_i || (data_req_i && $stable(req_payload_i)))
    else $error("bus request dropped or changed before its grant");

  no_proto_err: assert property (@(posedge clk) disable iff (!rst_n) !protocol_err_i)
    else $error("protocol error flag raised");

  cnt_limit: assert property (@(posedge clk) disable iff (!rst_n) granted_q <= 2'd2)
    else $error("more than two transfers outstanding");

endmodule

bind load_store_unit lsu_props i_lsu_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .data_req_i    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .req_payload_i (data_req_payload_o),
  .valid_0_i     (valid_0_i),
  .data_rvalid_i (data_rvalid_i),
  .protocol_err_i(protocol_err_o)
);

/* testbench/lsu_tb.sv */
// Testbench for the load/store unit: stimulus, memory model, reference and checker
// Run through run.sh; ends with a pass or fail line

`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int N_OPS       = 86;
  localparam int TIMEOUT_CYC = N_OPS * 12 + 200;

  typedef struct packed {
    logic [31:0] due;
    logic [31:0] rdata;
    logic        err;
  } resp_t;

  typedef struct packed {
    logic        chk;
    logic [31:0] val;
    logic        err;
  } exp_t;

  logic clk;
  logic rst_n;

  // DUT inputs
  lsu_op_t   op          = '0;
  logic      valid_0     = 1'b0;
  logic      data_gnt    = 1'b0;
  logic      data_rvalid = 1'b0;
  bus_resp_t data_resp   = '0;

  // DUT outputs
  logic        ready_0;
  logic        valid_0_ex;
  logic        ready_1;
  logic        valid_1;
  logic        data_req;
  bus_req_t    req_payload;
  logic [31:0] rdata_1;
  logic        err_1;
  logic        split_0;
  logic        first_op_0;
  logic        last_op_0;
  logic        busy;
  logic        interruptible;
  logic        protocol_err;

  integer      grant_seed = 32'h9d4f_e1e3;
  integer      op_seed    = 32'h9d4f_e1e3;
  logic [31:0] cyc        = '0;
  logic [1:0]  grant_wait = '0;
  logic        err_next   = 1'b0;
  int          half       = 0;

  // Bus memory and the shadow the reference reads
  logic [31:0] mem     [64];
  logic [31:0] ref_mem [64];
  resp_t       resp_q[$];
  exp_t        exp_q[$];

  // Op currently on the EX side
  logic [31:0] cur_addr;
  lsu_size_e   cur_size;
  logic        cur_we;
  logic [31:0] cur_wdata;
  logic        cur_split;
  logic [31:0] cur_exp;
  logic        cur_err;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  load_store_unit i_load_store_unit (
    .clk               (clk),
    .rst_n             (rst_n),
    .op_i              (op),
    .valid_0_i         (valid_0),
    .ready_0_o         (ready_0),
    .valid_0_o         (valid_0_ex),
    .ready_0_i         (1'b1),
    .valid_1_i         (1'b1),
    .ready_1_o         (ready_1),
    .valid_1_o         (valid_1),
    .ready_1_i         (1'b1),
    .data_req_o        (data_req),
    .data_req_payload_o(req_payload),
    .data_gnt_i        (data_gnt),
    .data_rvalid_i     (data_rvalid),
    .data_resp_i       (data_resp),
    .lsu_rdata_1_o     (rdata_1),
    .lsu_err_1_o       (err_1),
    .split_0_o         (split_0),
    .first_op_0_o      (first_op_0),
    .last_op_0_o       (last_op_0),
    .busy_o            (busy),
    .interruptible_o   (interruptible),
    .protocol_err_o    (protocol_err)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Initial memory contents, every word different
  function automatic logic [31:0] fill_word(input int i);
    return {8'(i), 8'(i * 3 + 1), 8'(i * 7 + 2), 8'(~i)};
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    case (size)
      LSU_SIZE_BYTE: return 1;
      LSU_SIZE_HALF: return 2;
      default:       return 4;
    endcase
  endfunction

  // Crosses a word boundary
  function automatic logic is_split(input logic [31:0] addr, input lsu_size_e size);
    return (int'(addr[1:0]) + size_bytes(size)) > 4;
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] addr, input lsu_size_e size,
                                           input logic sext);
    logic [31:0] v;
    logic [31:0] a;
    int          n;
    n = size_bytes(size);
    v = '0;
    for (int k = 0; k < n; k++) begin
      a = addr + 32'(k);
      v[8*k +: 8] = ref_mem[a[7:2]][{a[1:0], 3'b000} +: 8];
    end
    if (sext && n == 1) v[31:8] = {24{v[7]}};
    if (sext && n == 2) v[31:16] = {16{v[15]}};
    return v;
  endfunction

  task automatic ref_store(input logic [31:0] addr, input lsu_size_e size,
                           input logic [31:0] wdata);
    logic [31:0] a;
    for (int k = 0; k < size_bytes(size); k++) begin
      a = addr + 32'(k);
      ref_mem[a[7:2]][{a[1:0], 3'b000} +: 8] = wdata[8*k +: 8];
    end
  endtask

  // Expected address phase for one half of an access
  function automatic bus_req_t ref_req(input logic [31:0] addr, input lsu_size_e size,
                                       input logic we, input logic [31:0] wdata, input int hf);
    bus_req_t r;
    int       off;
    int       lane;
    off     = int'(addr[1:0]);
    r.we    = we;
    r.be    = '0;
    r.addr  = (hf == 0) ? addr : ({addr[31:2], 2'b00} + 32'd4);
    for (int l = 0; l < 4; l++) begin
      r.wdata[8*l +: 8] = wdata[8*((l - off) & 3) +: 8];
    end
    for (int k = 0; k < size_bytes(size); k++) begin
      lane = off + k;
      if (hf == 0 && lane < 4) r.be[lane] = 1'b1;
      if (hf == 1 && lane >= 4) r.be[lane - 4] = 1'b1;
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Error %s expected %h actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Memory responder
  //////////////////////////////////////////////////

  initial begin : responder
    logic [31:0] r;
    resp_t       ent;
    logic [5:0]  idx;
    for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
    forever begin
      @(posedge clk);
      if (rst_n && data_req) begin
        if (data_gnt) begin
          idx = req_payload.addr[7:2];
          if (req_payload.we) begin
            for (int l = 0; l < 4; l++) begin
              if (req_payload.be[l]) mem[idx][8*l +: 8] = req_payload.wdata[8*l +: 8];
            end
          end
          r          = $random(grant_seed);
          grant_wait = r[1:0];
          r          = $random(grant_seed);
          ent.due    = cyc + 32'd1 + (r % 32'd3);
          ent.rdata  = mem[idx];
          ent.err    = err_next;
          resp_q.push_back(ent);
        end else if (grant_wait != 2'd0) begin
          grant_wait = grant_wait - 2'd1;
        end
      end
      @(negedge clk);
      cyc = cyc + 32'd1;
      // Idle cycles carry junk, err included
      r           = $random(grant_seed);
      data_rvalid = 1'b0;
      data_resp   = {r, r[0]};
      if (resp_q.size() != 0 && resp_q[0].due <= cyc) begin
        ent         = resp_q.pop_front();
        data_rvalid = 1'b1;
        data_resp   = {ent.rdata, ent.err};
      end
      data_gnt = (grant_wait == 2'd0);
    end
  end

  //////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////

  always @(posedge clk) begin : compare
    bus_req_t exp_req;
    exp_t     e;
    logic     last;
    logic     req_exp;
    if (rst_n) begin
      // Request only below two in flight, WB ready when empty or on a response
      req_exp = valid_0 && (exp_q.size() < 2);
      check_val("data_req", 32'(req_exp), 32'(data_req));
      check_val("valid_0", 32'(req_exp && data_gnt), 32'(valid_0_ex));
      check_val("ready_1", 32'(data_rvalid || exp_q.size() == 0), 32'(ready_1));
      if (data_rvalid) begin
        if (exp_q.size() == 0) begin
          $display("Response arrived with no transfer expected");
          $display("TESTS FAILED");
          $fatal(1, "unexpected response");
        end
        e = exp_q.pop_front();
        check_val("valid_1", 32'd1, 32'(valid_1));
        check_val("resp_err", 32'(e.err), 32'(err_1));
        if (e.chk) check_val("load_data", e.val, rdata_1);
      end else begin
        check_val("idle_err", 32'd0, 32'(err_1));
        check_val("idle_valid_1", 32'd0, 32'(valid_1));
      end
      if (data_req && data_gnt) begin
        exp_req = ref_req(cur_addr, cur_size, cur_we, cur_wdata, half);
        last    = !cur_split || half == 1;
        check_val("req_addr", exp_req.addr, req_payload.addr);
        check_val("req_be", 32'(exp_req.be), 32'(req_payload.be));
        check_val("req_we", 32'(exp_req.we), 32'(req_payload.we));
        check_val("req_wdata", exp_req.wdata, req_payload.wdata);
        check_val("split_0", 32'(cur_split && half == 0), 32'(split_0));
        check_val("first_op_0", 32'(half == 0), 32'(first_op_0));
        check_val("last_op_0", 32'(last), 32'(last_op_0));
        check_val("ready_0", 32'(last), 32'(ready_0));
        e.chk = !cur_we && last;
        e.val = cur_exp;
        e.err = cur_err;
        exp_q.push_back(e);
        half = last ? 0 : 1;
      end else if (valid_0) begin
        check_val("ready_0_hold", 32'd0, 32'(ready_0));
      end
    end
  end

  always @(posedge clk) begin
    if (cyc > 32'(TIMEOUT_CYC)) begin
      $display("Timeout: operations did not complete in time");
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Called on a falling edge, returns on a falling edge
  task automatic run_op(input logic [31:0] addr, input lsu_size_e size, input logic we,
                        input logic sext, input logic [31:0] wdata, input logic err);
    logic [31:0] base;
    logic        done;
    cur_addr  = addr;
    cur_size  = size;
    cur_we    = we;
    cur_wdata = wdata;
    cur_err   = err;
    cur_split = is_split(addr, size);
    cur_exp   = ref_load(addr, size, sext);
    if (we) ref_store(addr, size, wdata);
    // Split the address over both operands
    base           = $random(op_seed);
    op.operand_a   = base;
    op.operand_b   = addr - base;
    op.wdata       = wdata;
    op.we          = we;
    op.size        = size;
    op.sext        = sext;
    err_next       = err;
    valid_0        = 1'b1;
    done           = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = data_req && data_gnt && ready_0;
    end
    @(negedge clk);
    valid_0 = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    for (int i = 0; i < 64; i++) ref_mem[i] = fill_word(i);
    @(posedge rst_n);
    @(negedge clk);
    check_val("reset_req", 32'd0, 32'(data_req));
    check_val("reset_valid_0", 32'd0, 32'(valid_0_ex));
    check_val("reset_valid_1", 32'd0, 32'(valid_1));
    check_val("reset_busy", 32'd0, 32'(busy));
    check_val("reset_proto_err", 32'd0, 32'(protocol_err));
    check_val("reset_interruptible", 32'd1, 32'(interruptible));

    // Aligned stores, then word readback
    run_op(32'h10, LSU_SIZE_WORD, 1'b1, 1'b0, 32'hcafe_f00d, 1'b0);
    run_op(32'h14, LSU_SIZE_HALF, 1'b1, 1'b0, 32'h0000_beef, 1'b0);
    run_op(32'h16, LSU_SIZE_HALF, 1'b1, 1'b0, 32'h1234_5678, 1'b0);
    for (int o = 0; o < 4; o++) begin
      run_op(32'h18 + 32'(o), LSU_SIZE_BYTE, 1'b1, 1'b0, 32'h6b5a_49a0 + 32'(o), 1'b0);
    end
    for (int w = 0; w < 3; w++) begin
      run_op(32'h10 + 32'(4 * w), LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0);
    end

    // Sign bit set in every byte and halfword the loads below pick
    run_op(32'h20, LSU_SIZE_WORD, 1'b1, 1'b0, 32'h8cf1_a5d3, 1'b0);
    run_op(32'h24, LSU_SIZE_WORD, 1'b1, 1'b0, 32'hc39e_b75a, 1'b0);

    // Byte and halfword loads at each legal offset
    for (int o = 0; o < 4; o++) begin
      for (int s = 0; s < 2; s++) begin
        run_op(32'h20 + 32'(o), LSU_SIZE_BYTE, 1'b0, s[0], 32'h0, 1'b0);
      end
    end
    for (int o = 0; o < 3; o++) begin
      for (int s = 0; s < 2; s++) begin
        run_op(32'h24 + 32'(o), LSU_SIZE_HALF, 1'b0, s[0], 32'h0, 1'b0);
      end
    end

    // Misaligned loads
    for (int o = 1; o < 4; o++) begin
      run_op(32'h40 + 32'(o), LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0);
    end
    run_op(32'h47, LSU_SIZE_HALF, 1'b0, 1'b1, 32'h0, 1'b0);

    // Misaligned stores with readback of both words
    for (int o = 1; o < 4; o++) begin
      run_op(32'h50 + 32'(9 * o), LSU_SIZE_WORD, 1'b1, 1'b0, 32'h8877_6655 ^ 32'(o), 1'b0);
      run_op(32'h50 + 32'(8 * o), LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0);
      run_op(32'h54 + 32'(8 * o), LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0);
    end
    run_op(32'h73, LSU_SIZE_HALF, 1'b1, 1'b0, 32'h0000_a1b2, 1'b0);
    run_op(32'h70, LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0);
    run_op(32'h74, LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0);

    // Random back-to-back traffic, address wraps over the whole memory
    for (int n = 0; n < 40; n++) begin
      r = $random(op_seed);
      run_op({24'h0, r[7:0]}, (r[9:8] == 2'b11) ? LSU_SIZE_WORD : lsu_size_e'(r[9:8]),
             r[10], r[11], $random(op_seed), 1'b0);
    end

    // Bus errors, one on a split load
    run_op(32'h80, LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b1);
    run_op(32'h85, LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b1);
    run_op(32'h88, LSU_SIZE_BYTE, 1'b1, 1'b0, 32'h0000_00c3, 1'b1);
    run_op(32'h88, LSU_SIZE_WORD, 1'b0, 1'b0, 32'h0, 1'b0);

    // Drain and check the idle status
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_val("idle_busy", 32'd0, 32'(busy));
    check_val("idle_interruptible", 32'd1, 32'(interruptible));
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_addr_stage.sv
hdl/lsu_txn_ctrl.sv
hdl/lsu_rdata_align.sv
hdl/load_store_unit.sv
testbench/tb_clk_gen.sv
testbench/lsu_props.sv
testbench/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build the load/store unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module lsu_tb -o lsu_sim

# The simulator exits nonzero on a fatal check, so keep its output for the search
out=$(./obj_dir/lsu_sim) || true
echo "$out"

# Pass only when the pass line is present
echo "$out" | grep -q "^TESTS PASSED$"
